//--- trig_consts.svh
`ifndef TRIG_CONSTS_SVH
`define TRIG_CONSTS_SVH

// input beat layout, four ADC samples in 16-bit lanes
`define TRIG_LANES 4
`define TRIG_LANE_W 16
`define TRIG_SAMPLE_W 12
`define TRIG_BEAT_W 64

// baseline window, must stay a power of two
`define TRIG_BASELINE_BEATS 16
`define TRIG_BASELINE_LOG2 4

// trigger height above baseline in ADC counts
`define TRIG_THRESHOLD 400

// frame = header + pre + trigger beat + post
`define TRIG_PRE_BEATS 4
`define TRIG_POST_BEATS 6
`define TRIG_FRAME_BEATS 12

// output FIFO, at least one full frame deep
`define TRIG_FIFO_DEPTH 32
`define TRIG_FIFO_AW 5

// timestamp tick every TS_DIV clocks
`define TRIG_TS_W 32
`define TRIG_TS_DIV 5

`endif

//--- trig_pkg.sv
`default_nettype none

`include "trig_consts.svh"

package trig_pkg;

    // one ADC sample, without the lane padding
    typedef logic [`TRIG_SAMPLE_W-1:0] sample_t;

    // one stream word, input or output
    typedef logic [`TRIG_BEAT_W-1:0] beat_t;

    // prescaled tick count
    typedef logic [`TRIG_TS_W-1:0] timestamp_t;

    // header word fields, all bits above the baseline are zero
    localparam int HDR_TS_LSB = 0;
    localparam int HDR_TS_MSB = 31;
    localparam int HDR_BL_LSB = 32;
    localparam int HDR_BL_MSB = 43;

endpackage

`default_nettype wire

//--- baseline_estimator.sv
`timescale 1ns/10ps
`default_nettype none

`include "trig_consts.svh"

module baseline_estimator
    import trig_pkg::*;
(
    input  logic    axis_aclk,
    input  logic    arst_n,
    input  logic    in_valid,
    input  sample_t lane0,
    output sample_t baseline,
    output logic    baseline_valid
);

    localparam int SUM_W = `TRIG_SAMPLE_W + `TRIG_BASELINE_LOG2;
    localparam logic [`TRIG_BASELINE_LOG2-1:0] LAST_BEAT =
        `TRIG_BASELINE_LOG2'(`TRIG_BASELINE_BEATS - 1);

    logic [`TRIG_BASELINE_LOG2-1:0] beat_cnt;
    logic [SUM_W-1:0]               sum;
    logic [SUM_W-1:0]               sum_next;

    assign sum_next = sum + SUM_W'(lane0);

    always_ff @(posedge axis_aclk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            beat_cnt       <= '0;
            sum            <= '0;
            baseline       <= '0;
            baseline_valid <= 1'b0;
        end
        else if (in_valid && !baseline_valid)
        begin
            if (beat_cnt == LAST_BEAT)
            begin
                // window complete, divide by shifting and freeze
                baseline       <= sample_t'(sum_next >> `TRIG_BASELINE_LOG2);
                baseline_valid <= 1'b1;
            end
            else
            begin
                sum      <= sum_next;
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    // baseline is measured once per reset
    a_baseline_sticky: assert property (
        @(posedge axis_aclk) disable iff (!arst_n)
        baseline_valid |=> baseline_valid && $stable(baseline)
    );

endmodule

`default_nettype wire

//--- pretrigger_delay.sv
`timescale 1ns/10ps
`default_nettype none

`include "trig_consts.svh"

module pretrigger_delay
    import trig_pkg::*;
(
    input  logic  axis_aclk,
    input  logic  arst_n,
    input  logic  in_valid,
    input  beat_t in_beat,
    output beat_t delayed_beat
);

    localparam int STAGES = `TRIG_PRE_BEATS + 1;

    beat_t history [STAGES];

    // advances on accepted beats only, so gaps in the strobe do not age it
    always_ff @(posedge axis_aclk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int i = 0; i < STAGES; i++)
            begin
                history[i] <= '0;
            end
        end
        else if (in_valid)
        begin
            history[0] <= in_beat;
            for (int i = 1; i < STAGES; i++)
            begin
                history[i] <= history[i-1];
            end
        end
    end

    // oldest stage, PRE+1 accepted beats back
    assign delayed_beat = history[STAGES-1];

endmodule

`default_nettype wire

//--- capture_controller.sv
`timescale 1ns/10ps
`default_nettype none

`include "trig_consts.svh"

module capture_controller
    import trig_pkg::*;
(
    input  logic                   axis_aclk,
    input  logic                   arst_n,
    input  logic                   in_valid,
    input  beat_t                  in_beat,
    input  beat_t                  delayed_beat,
    input  sample_t                baseline,
    input  logic                   baseline_valid,
    input  logic [`TRIG_FIFO_AW:0] free_slots,
    output logic                   wr_en,
    output beat_t                  wr_data,
    output logic                   wr_last,
    output logic                   wr_user,
    output logic [15:0]            lost_count
);

    localparam int CNT_W = $clog2(`TRIG_FRAME_BEATS + 1);
    localparam int DIV_W = $clog2(`TRIG_TS_DIV);
    localparam logic [CNT_W-1:0] LAST_IDX = CNT_W'(`TRIG_FRAME_BEATS - 1);
    localparam logic [`TRIG_FIFO_AW:0] FRAME_SLOTS = (`TRIG_FIFO_AW + 1)'(`TRIG_FRAME_BEATS);

    logic [DIV_W-1:0]        div_cnt;
    timestamp_t              timestamp;
    logic                    prev_above;
    logic [CNT_W-1:0]        beat_cnt;
    logic [`TRIG_SAMPLE_W:0] level;
    logic                    above;
    logic                    idle;
    logic                    trig_hit;
    logic                    start;
    beat_t                   header;

    // one extra bit so baseline plus threshold cannot wrap
    assign level = {1'b0, baseline} + (`TRIG_SAMPLE_W + 1)'(`TRIG_THRESHOLD);

    always_comb
    begin
        above = 1'b0;
        for (int i = 0; i < `TRIG_LANES; i++)
        begin
            if ({1'b0, in_beat[i*`TRIG_LANE_W +: `TRIG_SAMPLE_W]} > level)
            begin
                above = 1'b1;
            end
        end
    end

    assign idle     = (beat_cnt == '0);
    // rising edge of the above flag, only once the baseline is known
    assign trig_hit = in_valid && baseline_valid && idle && above && !prev_above;
    assign start    = trig_hit && (free_slots >= FRAME_SLOTS);

    always_comb
    begin
        header = '0;
        header[HDR_TS_MSB:HDR_TS_LSB] = timestamp;
        header[HDR_BL_MSB:HDR_BL_LSB] = baseline;
    end

    assign wr_en   = start || (!idle && in_valid);
    assign wr_user = start;
    assign wr_last = !idle && in_valid && (beat_cnt == LAST_IDX);
    assign wr_data = start ? header : delayed_beat;

    // free-running timestamp with prescaler
    always_ff @(posedge axis_aclk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            div_cnt   <= '0;
            timestamp <= '0;
        end
        else if (div_cnt == DIV_W'(`TRIG_TS_DIV - 1))
        begin
            div_cnt   <= '0;
            timestamp <= timestamp + 1'b1;
        end
        else
        begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    always_ff @(posedge axis_aclk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            prev_above <= 1'b0;
            beat_cnt   <= '0;
            lost_count <= '0;
        end
        else
        begin
            if (in_valid)
            begin
                prev_above <= above && baseline_valid;
            end
            // header goes out with the trigger, then one word per accepted beat
            if (start)
            begin
                beat_cnt <= CNT_W'(1);
            end
            else if (!idle && in_valid)
            begin
                beat_cnt <= (beat_cnt == LAST_IDX) ? '0 : beat_cnt + 1'b1;
            end
            // no room for a whole frame, drop it and count
            if (trig_hit && !start && lost_count != '1)
            begin
                lost_count <= lost_count + 1'b1;
            end
        end
    end

    // room is reserved at the trigger, so no word of the frame can hit a full FIFO
    a_write_has_room: assert property (
        @(posedge axis_aclk) disable iff (!arst_n)
        wr_en |-> free_slots != '0
    );

    a_cnt_in_range: assert property (
        @(posedge axis_aclk) disable iff (!arst_n)
        beat_cnt <= CNT_W'(`TRIG_FRAME_BEATS)
    );

endmodule

`default_nettype wire

//--- frame_fifo.sv
`timescale 1ns/10ps
`default_nettype none

`include "trig_consts.svh"

module frame_fifo
    import trig_pkg::*;
(
    input  logic                   axis_aclk,
    input  logic                   arst_n,
    input  logic                   wr_en,
    input  beat_t                  wr_data,
    input  logic                   wr_last,
    input  logic                   wr_user,
    output logic [`TRIG_FIFO_AW:0] free_slots,
    output logic                   full,
    output logic                   m_tvalid,
    input  logic                   m_tready,
    output beat_t                  m_tdata,
    output logic                   m_tlast,
    output logic                   m_tuser
);

    localparam int ENTRY_W = `TRIG_BEAT_W + 2;
    localparam logic [`TRIG_FIFO_AW:0] DEPTH = (`TRIG_FIFO_AW + 1)'(`TRIG_FIFO_DEPTH);

    logic [ENTRY_W-1:0]     mem [`TRIG_FIFO_DEPTH];
    logic [`TRIG_FIFO_AW:0] wr_ptr;
    logic [`TRIG_FIFO_AW:0] rd_ptr;
    logic [`TRIG_FIFO_AW:0] mem_count;
    logic [`TRIG_FIFO_AW:0] occupancy;
    logic                   mem_empty;
    logic                   load;
    logic                   bypass;
    logic                   take_mem;

    assign mem_count = wr_ptr - rd_ptr;
    assign mem_empty = (mem_count == '0);
    // output stage counts as one entry
    assign occupancy  = mem_count + m_tvalid;
    assign free_slots = DEPTH - occupancy;
    assign full       = (occupancy == DEPTH);

    // output register free this cycle or being emptied
    assign load     = !m_tvalid || m_tready;
    // empty memory: a write goes straight to the output, visible next cycle
    assign bypass   = wr_en && mem_empty && load;
    assign take_mem = load && !mem_empty;

    always_ff @(posedge axis_aclk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            m_tvalid <= 1'b0;
        end
        else
        begin
            if (wr_en && !bypass)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (take_mem)
            begin
                rd_ptr   <= rd_ptr + 1'b1;
                m_tvalid <= 1'b1;
            end
            else if (bypass)
            begin
                m_tvalid <= 1'b1;
            end
            else if (m_tready)
            begin
                m_tvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge axis_aclk)
    begin
        if (wr_en && !bypass)
        begin
            mem[wr_ptr[`TRIG_FIFO_AW-1:0]] <= {wr_user, wr_last, wr_data};
        end
        if (take_mem)
        begin
            {m_tuser, m_tlast, m_tdata} <= mem[rd_ptr[`TRIG_FIFO_AW-1:0]];
        end
        else if (bypass)
        begin
            {m_tuser, m_tlast, m_tdata} <= {wr_user, wr_last, wr_data};
        end
    end

    a_no_write_full: assert property (
        @(posedge axis_aclk) disable iff (!arst_n)
        wr_en |-> !full
    );

    // stream rule, a stalled word may not change or vanish
    a_hold_stalled: assert property (
        @(posedge axis_aclk) disable iff (!arst_n)
        m_tvalid && !m_tready |=> m_tvalid && $stable({m_tuser, m_tlast, m_tdata})
    );

endmodule

`default_nettype wire

//--- waveform_trigger_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "trig_consts.svh"

module waveform_trigger_top
    import trig_pkg::*;
(
    input  logic        axis_aclk,
    input  logic        arst_n,
    input  logic        s_tvalid,
    input  beat_t       s_tdata,
    output logic        m_tvalid,
    input  logic        m_tready,
    output beat_t       m_tdata,
    output logic        m_tlast,
    output logic        m_tuser,
    output logic        fifo_full,
    output logic [15:0] lost_count
);

    sample_t                baseline;
    logic                   baseline_valid;
    beat_t                  delayed_beat;
    logic [`TRIG_FIFO_AW:0] free_slots;
    logic                   wr_en;
    beat_t                  wr_data;
    logic                   wr_last;
    logic                   wr_user;

    // baseline comes from lane 0 only
    baseline_estimator u_baseline (
        .axis_aclk      (axis_aclk),
        .arst_n         (arst_n),
        .in_valid       (s_tvalid),
        .lane0          (s_tdata[`TRIG_SAMPLE_W-1:0]),
        .baseline       (baseline),
        .baseline_valid (baseline_valid)
    );

    pretrigger_delay u_delay (
        .axis_aclk    (axis_aclk),
        .arst_n       (arst_n),
        .in_valid     (s_tvalid),
        .in_beat      (s_tdata),
        .delayed_beat (delayed_beat)
    );

    capture_controller u_ctrl (
        .axis_aclk      (axis_aclk),
        .arst_n         (arst_n),
        .in_valid       (s_tvalid),
        .in_beat        (s_tdata),
        .delayed_beat   (delayed_beat),
        .baseline       (baseline),
        .baseline_valid (baseline_valid),
        .free_slots     (free_slots),
        .wr_en          (wr_en),
        .wr_data        (wr_data),
        .wr_last        (wr_last),
        .wr_user        (wr_user),
        .lost_count     (lost_count)
    );

    frame_fifo u_fifo (
        .axis_aclk  (axis_aclk),
        .arst_n     (arst_n),
        .wr_en      (wr_en),
        .wr_data    (wr_data),
        .wr_last    (wr_last),
        .wr_user    (wr_user),
        .free_slots (free_slots),
        .full       (fifo_full),
        .m_tvalid   (m_tvalid),
        .m_tready   (m_tready),
        .m_tdata    (m_tdata),
        .m_tlast    (m_tlast),
        .m_tuser    (m_tuser)
    );

endmodule

`default_nettype wire

//--- trigger_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "trig_consts.svh"

module trigger_tb
    import trig_pkg::*;
();

    localparam int PERIOD      = 20;
    localparam int NUM_BEATS   = 900;
    localparam int MAX_GAP     = 4;
    localparam int FIRST_PULSE = 24;
    localparam int NOISE_LEVEL = 1000;
    localparam int LOW_START   = 400;
    localparam int LOW_END     = 800;
    localparam int FRAME       = `TRIG_FRAME_BEATS;
    localparam int WATCHDOG_NS = (NUM_BEATS * MAX_GAP + 200) * PERIOD;

    logic        axis_aclk;
    logic        arst_n;
    logic        s_tvalid;
    beat_t       s_tdata;
    logic        m_tvalid;
    logic        m_tready;
    beat_t       m_tdata;
    logic        m_tlast;
    logic        m_tuser;
    logic        fifo_full;
    logic [15:0] lost_count;

    // reference model state
    logic [31:0] rng_state;
    beat_t       sent [$];
    beat_t       exp_q [$];
    int          bl_sum;
    sample_t     bl_model;
    logic        prev_above;
    int          frame_left;
    int          written;
    int          popped;
    logic [15:0] lost_model;
    int          frames_started;
    int          frames_out;
    int          out_pos;
    logic [31:0] last_ts;
    int          edge_idx;

    // stimulus and checker state
    int          gap_run;
    int          pulse_wait;
    int          pulse_left;
    int          pulse_height;
    int          pulse_lane;
    logic        hold_pending;
    logic [65:0] hold_word;

    waveform_trigger_top UUT (
        .axis_aclk  (axis_aclk),
        .arst_n     (arst_n),
        .s_tvalid   (s_tvalid),
        .s_tdata    (s_tdata),
        .m_tvalid   (m_tvalid),
        .m_tready   (m_tready),
        .m_tdata    (m_tdata),
        .m_tlast    (m_tlast),
        .m_tuser    (m_tuser),
        .fifo_full  (fifo_full),
        .lost_count (lost_count)
    );

    initial
    begin
        axis_aclk = 1'b0;
        forever #(PERIOD / 2) axis_aclk = ~axis_aclk;
    end

    task automatic report_fail(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // noise on every lane, a pulse adds its height to one lane
    task automatic make_beat(output beat_t beat);
        logic [31:0] r;
        int          sample;
        int          height;
        height = 0;
        if (pulse_left > 0)
        begin
            height = pulse_height;
            pulse_left--;
        end
        else if (sent.size() >= FIRST_PULSE && sent.size() < NUM_BEATS - 20)
        begin
            if (pulse_wait == 0)
            begin
                r = next_rand();
                // heights from 200, so over a third stay under the threshold
                pulse_height = 200 + int'(r[9:0]) % 800;
                pulse_left   = int'(r[13:12]);
                pulse_lane   = int'(r[17:16]);
                pulse_wait   = 10 + int'(r[24:20]);
                height       = pulse_height;
            end
            else
            begin
                pulse_wait--;
            end
        end
        for (int i = 0; i < `TRIG_LANES; i++)
        begin
            r = next_rand();
            sample = NOISE_LEVEL + int'(r[2:0]) - 4;
            if (i == pulse_lane)
                sample = sample + height;
            beat[i*`TRIG_LANE_W +: `TRIG_LANE_W] = 16'(sample);
        end
    endtask

    // mirrors the trigger and frame rules for one rising edge
    task automatic model_edge(input logic valid, input beat_t data, input logic pop);
        logic  above;
        logic  bl_ok;
        int    level;
        int    idx;
        beat_t header;
        if (valid)
        begin
            bl_ok = (sent.size() >= `TRIG_BASELINE_BEATS);
            level = int'(bl_model) + `TRIG_THRESHOLD;
            above = 1'b0;
            for (int i = 0; i < `TRIG_LANES; i++)
            begin
                if (int'(data[i*`TRIG_LANE_W +: `TRIG_SAMPLE_W]) > level)
                    above = 1'b1;
            end
            if (frame_left > 0)
            begin
                // pre-trigger history, PRE+1 beats behind the input
                idx = sent.size() - (`TRIG_PRE_BEATS + 1);
                exp_q.push_back(sent[idx]);
                frame_left--;
                written++;
            end
            else if (bl_ok && above && !prev_above)
            begin
                if (`TRIG_FIFO_DEPTH - (written - popped) >= FRAME)
                begin
                    header = {20'h0, bl_model, 32'(edge_idx / `TRIG_TS_DIV)};
                    exp_q.push_back(header);
                    frame_left = FRAME - 1;
                    written++;
                    frames_started++;
                end
                else if (lost_model != 16'hffff)
                begin
                    lost_model++;
                end
            end
            prev_above = bl_ok && above;
            if (sent.size() < `TRIG_BASELINE_BEATS)
            begin
                bl_sum = bl_sum + int'(data[`TRIG_SAMPLE_W-1:0]);
                if (sent.size() == `TRIG_BASELINE_BEATS - 1)
                    bl_model = sample_t'(bl_sum >> `TRIG_BASELINE_LOG2);
            end
            sent.push_back(data);
        end
        if (pop)
            popped++;
    endtask

    task automatic check_state();
        if (sent.size() <= `TRIG_BASELINE_BEATS)
            assert (!m_tvalid)
                else report_fail("m_tvalid rose before the baseline window was complete");
        assert (lost_count == lost_model)
            else report_fail($sformatf("Mismatch lost_count: got 0x%h, expected 0x%h",
                                       lost_count, lost_model));
        assert (fifo_full == ((written - popped) == `TRIG_FIFO_DEPTH))
            else report_fail($sformatf("Mismatch fifo_full: got 0x%h, expected 0x%h",
                                       fifo_full,
                                       (written - popped) == `TRIG_FIFO_DEPTH));
        if (hold_pending)
        begin
            assert (m_tvalid)
                else report_fail("m_tvalid dropped while the word was stalled");
            assert ({m_tuser, m_tlast, m_tdata} == hold_word)
                else report_fail($sformatf("Mismatch m_tdata while stalled: got 0x%h, expected 0x%h",
                                           {m_tuser, m_tlast, m_tdata}, hold_word));
        end
    endtask

    task automatic check_word();
        beat_t exp;
        assert (exp_q.size() != 0)
            else report_fail("an output word appeared with no frame expected");
        exp = exp_q.pop_front();
        assert (m_tuser == (out_pos == 0))
            else report_fail($sformatf("Mismatch m_tuser: got 0x%h, expected 0x%h",
                                       m_tuser, out_pos == 0));
        assert (m_tlast == (out_pos == FRAME - 1))
            else report_fail($sformatf("Mismatch m_tlast: got 0x%h, expected 0x%h",
                                       m_tlast, out_pos == FRAME - 1));
        if (m_tuser)
        begin
            assert (m_tdata[43:32] == bl_model)
                else report_fail($sformatf("Mismatch m_tdata baseline: got 0x%h, expected 0x%h",
                                           m_tdata[43:32], bl_model));
            assert (m_tdata[63:44] == '0)
                else report_fail($sformatf("Mismatch m_tdata upper header bits: got 0x%h, expected 0x0",
                                           m_tdata[63:44]));
            if (frames_out > 0)
                assert (m_tdata[31:0] > last_ts)
                    else report_fail("header timestamp did not increase from the previous frame");
            last_ts = m_tdata[31:0];
        end
        assert (m_tdata == exp)
            else report_fail($sformatf("Mismatch m_tdata: got 0x%h, expected 0x%h",
                                       m_tdata, exp));
        if (out_pos == FRAME - 1)
        begin
            out_pos = 0;
            frames_out++;
        end
        else
        begin
            out_pos++;
        end
    endtask

    // one clock: check settled outputs, drive inputs, model the next rising edge
    task automatic run_cycle(input bit stim_on);
        logic [31:0] r;
        logic        valid;
        logic        ready;
        logic        pop;
        beat_t       beat;
        check_state();
        valid = 1'b0;
        if (stim_on)
        begin
            r = next_rand();
            valid = (r[1:0] != 2'b00) || (gap_run >= MAX_GAP - 1);
        end
        gap_run = valid ? 0 : gap_run + 1;
        if (valid)
            make_beat(beat);
        else
            beat = {next_rand(), next_rand()};
        if (!stim_on)
            ready = 1'b1;
        else if (edge_idx >= LOW_START && edge_idx < LOW_END)
            ready = 1'b0;
        else
        begin
            r = next_rand();
            ready = r[0] | r[1];
        end
        s_tvalid = valid;
        s_tdata  = beat;
        m_tready = ready;
        pop = m_tvalid && m_tready;
        if (pop)
            check_word();
        hold_pending = m_tvalid && !m_tready;
        hold_word    = {m_tuser, m_tlast, m_tdata};
        model_edge(valid, beat, pop);
        edge_idx++;
        @(negedge axis_aclk);
    endtask

    initial
    begin
        #(WATCHDOG_NS);
        report_fail("watchdog expired before the test sequence finished");
    end

    initial
    begin
        arst_n         = 1'b0;
        s_tvalid       = 1'b0;
        s_tdata        = '0;
        m_tready       = 1'b0;
        rng_state      = 32'ha7be_8aeb;
        bl_sum         = 0;
        bl_model       = '0;
        prev_above     = 1'b0;
        frame_left     = 0;
        written        = 0;
        popped         = 0;
        lost_model     = '0;
        frames_started = 0;
        frames_out     = 0;
        out_pos        = 0;
        last_ts        = '0;
        edge_idx       = 0;
        gap_run        = 0;
        pulse_wait     = 0;
        pulse_left     = 0;
        pulse_height   = 0;
        pulse_lane     = 0;
        hold_pending   = 1'b0;
        hold_word      = '0;
        repeat (2) @(posedge axis_aclk);
        @(negedge axis_aclk);
        arst_n = 1'b1;

        while (sent.size() < NUM_BEATS)
            run_cycle(1'b1);
        // drain with ready high, then a few idle cycles for stray words
        while (exp_q.size() != 0)
            run_cycle(1'b0);
        repeat (8) run_cycle(1'b0);

        assert (lost_model > 0)
            else report_fail("no trigger was dropped while the FIFO was full");
        assert (frames_started > 0)
            else report_fail("no frame was captured");
        if (exp_q.size() == 0 && frames_out == frames_started && out_pos == 0 && frame_left == 0)
        begin
            $display("Simulation completed successfully");
            $finish;
        end
        else
        begin
            report_fail("frames were lost or duplicated by the end of the run");
        end
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+.
trig_pkg.sv
baseline_estimator.sv
pretrigger_delay.sv
capture_controller.sv
frame_fifo.sv
waveform_trigger_top.sv
trigger_tb.sv

//--- Makefile
# Verilator flow for the waveform trigger project
# override any variable on the command line, e.g. make sim BUILD_DIR=obj

VERILATOR  ?= verilator
TOP        ?= trigger_tb
FILELIST   ?= sources.f
BUILD_DIR  ?= build
JOBS       ?= 4
LINT_FLAGS ?= --lint-only -Wall --timing
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(SIM_FLAGS) -j $(JOBS) --Mdir $(BUILD_DIR) \
		--top-module $(TOP) -f $(FILELIST)

# the simulator exits non-zero on $fatal, so make fails with it
sim: build
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
